// File: verilog/synth_defines.svh
// synth build constants
`ifndef SYNTH_DEFINES_SVH
`define SYNTH_DEFINES_SVH

// ----------------------------------------------------------------------
// clocking
// ----------------------------------------------------------------------

// system clock in Hz
`define CLK_FREQ 10000000

// clocks per uart bit, sized for simulation
// real midi wiring would need CLK_FREQ / 31250
`define UART_BIT_CLKS 16

// clocks per audio sample
`define SMPL_DIV 64

// ----------------------------------------------------------------------
// voice setup
// ----------------------------------------------------------------------

// midi receive channel, zero based
`define MIDI_CHANNEL 0

// pan after reset, centre of 0..127
`define PAN_DEFAULT 64

`endif

// File: verilog/synth_pkg.sv
// synth shared types
package synth_pkg;

    // ------------------------------------------------------------------
    // midi message as seen by the voice
    // ------------------------------------------------------------------

    typedef struct packed {
        // status high nibble
        logic [3:0] cmd;
        // status low nibble
        logic [3:0] channel;
        // first data byte
        logic [6:0] data0;
        // second data byte, zero for one-byte messages
        logic [6:0] data1;
    } midi_msg_t;

    // one stereo audio sample, two's complement
    typedef struct packed {
        logic signed [17:0] left;
        logic signed [17:0] right;
    } stereo_sample_t;

    // channel voice command codes
    localparam logic [3:0] CMD_NOTE_OFF      = 4'h8;
    localparam logic [3:0] CMD_NOTE_ON       = 4'h9;
    localparam logic [3:0] CMD_CTRL_CHANGE   = 4'hB;
    localparam logic [3:0] CMD_PROG_CHANGE   = 4'hC;
    localparam logic [3:0] CMD_CHAN_PRESSURE = 4'hD;

    // controller number for pan
    localparam logic [6:0] CC_PAN = 7'd10;

endpackage

// File: verilog/uart_rx.sv
// uart 8N1 receiver
`timescale 1ns/1ps
`include "synth_defines.svh"

module uart_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    output logic       byte_valid,
    output logic [7:0] rx_byte
);

    localparam int CNT_W = $clog2(`UART_BIT_CLKS);

    // sync[0] meta, sync[1] synced, sync[2] previous synced
    logic [2:0]       sync_q;
    logic             rx_s;
    logic             start_edge;
    logic             busy_q;
    logic [CNT_W-1:0] clk_cnt_q;
    logic [3:0]       bit_idx_q;
    logic             mid_bit;
    logic [7:0]       shift_q;

    assign rx_s       = sync_q[1];
    assign start_edge = sync_q[2] & ~sync_q[1];
    // counter runs one behind the synced edge, so this hits mid-bit
    assign mid_bit    = busy_q && (clk_cnt_q == CNT_W'(`UART_BIT_CLKS / 2 - 1));
    assign rx_byte    = shift_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // idle line is high
            sync_q     <= 3'b111;
            busy_q     <= 1'b0;
            clk_cnt_q  <= '0;
            bit_idx_q  <= '0;
            byte_valid <= 1'b0;
        end else begin
            sync_q     <= {sync_q[1:0], rx};
            byte_valid <= 1'b0;
            if (!busy_q) begin
                if (start_edge) begin
                    busy_q    <= 1'b1;
                    clk_cnt_q <= CNT_W'(1);
                    bit_idx_q <= '0;
                end
            end else begin
                if (clk_cnt_q == CNT_W'(`UART_BIT_CLKS - 1))
                    clk_cnt_q <= '0;
                else
                    clk_cnt_q <= clk_cnt_q + CNT_W'(1);
                if (mid_bit) begin
                    bit_idx_q <= bit_idx_q + 4'd1;
                    // glitch, start bit gone high again
                    if (bit_idx_q == 4'd0 && rx_s)
                        busy_q <= 1'b0;
                    // stop bit, strobe only when it is high
                    if (bit_idx_q == 4'd9) begin
                        busy_q     <= 1'b0;
                        byte_valid <= rx_s;
                    end
                end
            end
        end
    end

    // data bits, lsb first
    always_ff @(posedge clk) begin
        if (mid_bit && bit_idx_q >= 4'd1 && bit_idx_q <= 4'd8)
            shift_q <= {rx_s, shift_q[7:1]};
    end

endmodule

// File: verilog/midi_decoder.sv
// midi byte stream parser
`timescale 1ns/1ps

module midi_decoder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  byte_valid,
    input  logic [7:0]            rx_byte,
    output logic                  msg_valid,
    output synth_pkg::midi_msg_t  msg
);

    // running status
    logic [3:0] cmd_q;
    logic [3:0] chan_q;
    logic       status_ok_q;
    // first data byte seen for a two-byte message
    logic       have_d0_q;
    logic [6:0] data0_q;

    logic is_realtime;
    logic is_system;
    logic is_status;
    logic one_data;
    logic msg_done;

    assign is_realtime = rx_byte[7:3] == 5'b11111;
    assign is_system   = rx_byte[7:4] == 4'hF;
    assign is_status   = rx_byte[7];
    assign one_data    = (cmd_q == synth_pkg::CMD_PROG_CHANGE) ||
                         (cmd_q == synth_pkg::CMD_CHAN_PRESSURE);
    // data byte that closes a message
    assign msg_done    = byte_valid && !is_status && status_ok_q &&
                         (one_data || have_d0_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_q       <= '0;
            chan_q      <= '0;
            status_ok_q <= 1'b0;
            have_d0_q   <= 1'b0;
            msg_valid   <= 1'b0;
        end else begin
            msg_valid <= msg_done;
            // realtime bytes fall through untouched
            if (byte_valid && !is_realtime) begin
                if (is_system) begin
                    // sysex and common messages end running status
                    status_ok_q <= 1'b0;
                    have_d0_q   <= 1'b0;
                end else if (is_status) begin
                    cmd_q       <= rx_byte[7:4];
                    chan_q      <= rx_byte[3:0];
                    status_ok_q <= 1'b1;
                    have_d0_q   <= 1'b0;
                end else if (status_ok_q && !one_data) begin
                    have_d0_q <= !have_d0_q;
                end
            end
        end
    end

    // first data byte and message payload
    always_ff @(posedge clk) begin
        if (byte_valid && !is_status && !have_d0_q)
            data0_q <= rx_byte[6:0];
        if (msg_done) begin
            msg.cmd     <= cmd_q;
            msg.channel <= chan_q;
            msg.data0   <= one_data ? rx_byte[6:0] : data0_q;
            msg.data1   <= one_data ? 7'd0 : rx_byte[6:0];
        end
    end

endmodule

// File: verilog/sample_rate_ctrl.sv
// audio sample tick divider
`timescale 1ns/1ps
`include "synth_defines.svh"

module sample_rate_ctrl (
    input  logic clk,
    input  logic rst_n,
    output logic sample_tick
);

    localparam int CNT_W = $clog2(`SMPL_DIV);

    logic [CNT_W-1:0] cnt_q;
    logic             wrap;

    assign wrap = cnt_q == CNT_W'(`SMPL_DIV - 1);

    // tick registered on the wrap, first one SMPL_DIV clocks out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q       <= '0;
            sample_tick <= 1'b0;
        end else begin
            cnt_q       <= wrap ? '0 : cnt_q + CNT_W'(1);
            sample_tick <= wrap;
        end
    end

endmodule

// File: verilog/gen_pulse.sv
// square wave voice with pan
`timescale 1ns/1ps
`include "synth_defines.svh"

module gen_pulse (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      msg_valid,
    input  synth_pkg::midi_msg_t      msg,
    input  logic                      sample_tick,
    output logic                      sample_valid,
    output synth_pkg::stereo_sample_t sample
);

    // ------------------------------------------------------------------
    // note state
    // ------------------------------------------------------------------

    logic [6:0] note_q;
    logic [6:0] vel_q;
    logic [6:0] pan_q;
    logic       gate_q;
    // position inside the half period and current sign
    logic [7:0] ph_cnt_q;
    logic       neg_q;

    logic       for_us;
    logic       note_on;
    logic       note_off;
    logic       set_pan;
    logic [7:0] half_period;
    logic [7:0] ph_next;
    logic [6:0] pan_inv;
    logic [13:0] prod_l;
    logic [13:0] prod_r;
    logic signed [17:0] amp_l;
    logic signed [17:0] amp_r;

    assign for_us   = msg_valid && (msg.channel == 4'(`MIDI_CHANNEL));
    assign note_on  = for_us && msg.cmd == synth_pkg::CMD_NOTE_ON && msg.data1 != 7'd0;
    // velocity zero note on counts as note off
    assign note_off = for_us && msg.data0 == note_q &&
                      (msg.cmd == synth_pkg::CMD_NOTE_OFF ||
                       (msg.cmd == synth_pkg::CMD_NOTE_ON && msg.data1 == 7'd0));
    assign set_pan  = for_us && msg.cmd == synth_pkg::CMD_CTRL_CHANGE &&
                      msg.data0 == synth_pkg::CC_PAN;

    // half period in samples, 1..128
    assign half_period = 8'd128 - {1'b0, note_q};
    assign ph_next     = ph_cnt_q + 8'd1;

    // amplitude = velocity * pan gain * 4
    assign pan_inv = 7'd127 - pan_q;
    assign prod_l  = vel_q * pan_inv;
    assign prod_r  = vel_q * pan_q;
    assign amp_l   = {2'b00, prod_l, 2'b00};
    assign amp_r   = {2'b00, prod_r, 2'b00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            note_q       <= '0;
            vel_q        <= '0;
            pan_q        <= 7'(`PAN_DEFAULT);
            gate_q       <= 1'b0;
            ph_cnt_q     <= '0;
            neg_q        <= 1'b0;
            sample_valid <= 1'b0;
            sample       <= '0;
        end else begin
            sample_valid <= sample_tick;
            if (sample_tick) begin
                sample.left  <= !gate_q ? 18'sd0 : (neg_q ? -amp_l : amp_l);
                sample.right <= !gate_q ? 18'sd0 : (neg_q ? -amp_r : amp_r);
                // step phase, flip sign at the end of each half
                ph_cnt_q <= (ph_next == half_period) ? 8'd0 : ph_next;
                neg_q    <= (ph_next == half_period) ? !neg_q : neg_q;
            end
            // messages win over the phase step
            if (note_on) begin
                note_q   <= msg.data0;
                vel_q    <= msg.data1;
                gate_q   <= 1'b1;
                ph_cnt_q <= '0;
                neg_q    <= 1'b0;
            end else if (note_off) begin
                gate_q <= 1'b0;
            end
            if (set_pan)
                pan_q <= msg.data1;
        end
    end

endmodule

// File: verilog/stereo_dac_output.sv
// stereo sigma-delta dac
`timescale 1ns/1ps

module stereo_dac_output (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      sample_valid,
    input  synth_pkg::stereo_sample_t sample,
    output logic                      dac_out_l,
    output logic                      dac_out_r
);

    // index 0 left, 1 right
    logic signed [17:0] smpl_q [2];
    logic [17:0]        level  [2];
    logic [17:0]        acc_q  [2];
    logic [1:0]         dac_q;

    // offset binary, sample + 2^17 is the msb flipped
    always_comb begin
        for (int i = 0; i < 2; i++)
            level[i] = {~smpl_q[i][17], smpl_q[i][16:0]};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2; i++) begin
                smpl_q[i] <= '0;
                acc_q[i]  <= '0;
            end
            dac_q <= '0;
        end else begin
            if (sample_valid) begin
                smpl_q[0] <= sample.left;
                smpl_q[1] <= sample.right;
            end
            // first order modulator, carry out is the bit
            for (int i = 0; i < 2; i++)
                {dac_q[i], acc_q[i]} <= {1'b0, acc_q[i]} + {1'b0, level[i]};
        end
    end

    assign dac_out_l = dac_q[0];
    assign dac_out_r = dac_q[1];

endmodule

// File: verilog/synth_top.sv
// midi pulse synth top
`timescale 1ns/1ps

// clk runs at CLK_FREQ, rst_n straight from the board pin
module synth_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      midi_rx,
    output logic                      dac_out_l,
    output logic                      dac_out_r,
    output logic                      sample_valid,
    output synth_pkg::stereo_sample_t sample
);

    logic                 byte_valid;
    logic [7:0]           rx_byte;
    logic                 msg_valid;
    synth_pkg::midi_msg_t msg;
    logic                 sample_tick;

    // ------------------------------------------------------------------
    // midi input side
    // ------------------------------------------------------------------

    uart_rx uart_rx_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx         (midi_rx),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte)
    );

    midi_decoder midi_decoder_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte),
        .msg_valid  (msg_valid),
        .msg        (msg)
    );

    // ------------------------------------------------------------------
    // audio side
    // ------------------------------------------------------------------

    sample_rate_ctrl sample_rate_ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_tick (sample_tick)
    );

    gen_pulse gen_pulse_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .msg_valid    (msg_valid),
        .msg          (msg),
        .sample_tick  (sample_tick),
        .sample_valid (sample_valid),
        .sample       (sample)
    );

    // dac taps the same stream that leaves the chip
    stereo_dac_output stereo_dac_output_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample       (sample),
        .dac_out_l    (dac_out_l),
        .dac_out_r    (dac_out_r)
    );

endmodule

// File: testbench/tb_clock.sv
// testbench clock and reset
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    localparam int HALF_PERIOD = 50;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // low for four rising edges, released just after the fourth
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: testbench/synth_tb.sv
// pulse synth testbench
`timescale 1ns/1ps
`include "synth_defines.svh"

module synth_tb;

    // tests take about 20k cycles, ten times that as ceiling
    localparam int MAX_CYCLES  = 200000;
    // one 8N1 frame plus one idle bit
    localparam int FRAME_CLKS  = 11 * `UART_BIT_CLKS;
    // start edge to voice update
    // stop bit sample, sync, decoder and voice register
    localparam int UPDATE_CLKS = (19 * `UART_BIT_CLKS) / 2 + 4;

    logic                      clk;
    logic                      rst_n;
    logic                      midi_rx;
    logic                      dac_out_l;
    logic                      dac_out_r;
    logic                      sample_valid;
    synth_pkg::stereo_sample_t sample;

    int         seed = 32138;
    int         cycles = 0;
    int         smp_cnt = 0;
    int         last_valid_cyc = -1;
    logic [7:0] tx_q [$];

    // expected voice state
    int exp_note = 0;
    int exp_vel = 0;
    int exp_pan = `PAN_DEFAULT;
    bit exp_gate = 1'b0;
    // sample index where the current note started
    int phase_base = 0;
    bit check_en = 1'b0;

    // sigma-delta model, index 0 left, 1 right
    logic [17:0]               m_smpl [2];
    logic [17:0]               m_acc [2];
    logic [1:0]                m_dac;
    logic                      prev_valid;
    synth_pkg::stereo_sample_t prev_sample;
    logic                      rst_prev = 1'b0;

    tb_clock clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    synth_top synth_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .midi_rx      (midi_rx),
        .dac_out_l    (dac_out_l),
        .dac_out_r    (dac_out_r),
        .sample_valid (sample_valid),
        .sample       (sample)
    );

    task automatic report_fail(input string what);
        $display("Fail at %0t: %s", $time, what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    // ------------------------------------------------------------------
    // reference models
    // ------------------------------------------------------------------

    // square wave, k samples after note on
    function automatic synth_pkg::stereo_sample_t expected_sample(input int k);
        synth_pkg::stereo_sample_t s;
        int half;
        int amp_l;
        int amp_r;
        half  = 128 - exp_note;
        amp_l = exp_vel * (127 - exp_pan) * 4;
        amp_r = exp_vel * exp_pan * 4;
        // odd half periods are negative
        if ((k / half) % 2 == 1) begin
            amp_l = -amp_l;
            amp_r = -amp_r;
        end
        if (!exp_gate) begin
            amp_l = 0;
            amp_r = 0;
        end
        s.left  = amp_l[17:0];
        s.right = amp_r[17:0];
        return s;
    endfunction

    // sample spacing and value
    always @(negedge clk) begin
        synth_pkg::stereo_sample_t exp_s;
        if (rst_n && sample_valid) begin
            if (last_valid_cyc >= 0) begin
                assert (cycles - last_valid_cyc == `SMPL_DIV) else
                    report_fail($sformatf("sample_valid after %0d cycles",
                                          cycles - last_valid_cyc));
            end
            last_valid_cyc = cycles;
            if (check_en) begin
                exp_s = expected_sample(smp_cnt - phase_base);
                assert (sample == exp_s) else
                    report_fail($sformatf("sample %h, expected %h", sample, exp_s));
            end
            smp_cnt++;
        end
    end

    // dac bitstream from the observed samples
    // rst_n only moves just after a rising edge
    always @(negedge clk) begin
        logic [18:0] dac_sum;
        if (!rst_n || !rst_prev) begin
            for (int i = 0; i < 2; i++) begin
                m_smpl[i] = '0;
                m_acc[i]  = '0;
            end
            m_dac = '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                // offset binary, sample + 2^17 wrapped to 18 bits
                dac_sum  = {1'b0, m_acc[i]} + {1'b0, m_smpl[i] + 18'h20000};
                m_dac[i] = dac_sum[18];
                m_acc[i] = dac_sum[17:0];
            end
            // latch seen before the last rising edge
            if (prev_valid) begin
                m_smpl[0] = prev_sample.left;
                m_smpl[1] = prev_sample.right;
            end
        end
        assert (dac_out_l == m_dac[0] && dac_out_r == m_dac[1]) else
            report_fail($sformatf("dac bits l=%b r=%b, expected l=%b r=%b",
                                  dac_out_l, dac_out_r, m_dac[0], m_dac[1]));
        prev_valid  = sample_valid;
        prev_sample = sample;
        rst_prev    = rst_n;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d clock cycles", MAX_CYCLES);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    // ------------------------------------------------------------------
    // midi driver
    // ------------------------------------------------------------------

    // start, 8 data lsb first, stop, one idle bit
    task automatic send_byte(input logic [7:0] b);
        logic [10:0] frame;
        frame = {2'b11, b, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            #1 midi_rx = frame[i];
            repeat (`UART_BIT_CLKS - 1) @(posedge clk);
        end
    endtask

    // delay that puts the voice update mid-way between two ticks
    function automatic int align_delay(input int n_bytes);
        int upd;
        upd = FRAME_CLKS * (n_bytes - 1) + UPDATE_CLKS;
        return ((`SMPL_DIV / 2 - upd) % `SMPL_DIV + `SMPL_DIV) % `SMPL_DIV;
    endfunction

    task automatic send_queued();
        int d;
        int start;
        d     = align_delay(tx_q.size());
        start = smp_cnt;
        // line up with the sample grid
        while (smp_cnt == start) @(posedge clk);
        repeat (d) @(posedge clk);
        while (tx_q.size() > 0)
            send_byte(tx_q.pop_front());
    endtask

    task automatic wait_samples(input int n);
        int target;
        target = smp_cnt + n;
        while (smp_cnt < target) @(posedge clk);
    endtask

    task automatic check_window(input int n);
        @(posedge clk);
        check_en = 1'b1;
        wait_samples(n);
        check_en = 1'b0;
    endtask

    // note on restarts the phase at the next sample
    task automatic start_note(input int note, input int vel);
        exp_note   = note;
        exp_vel    = vel;
        exp_gate   = 1'b1;
        phase_base = smp_cnt;
    endtask

    function automatic int random_velocity();
        int rnd;
        rnd = $random(seed);
        return (rnd & 32'h7fff_ffff) % 127 + 1;
    endfunction

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------

    task automatic test_idle();
        exp_gate = 1'b0;
        check_window(8);
    endtask

    task automatic test_note_on();
        int vel;
        vel = random_velocity();
        tx_q = '{8'h90, 8'd100, 8'(vel)};
        send_queued();
        start_note(100, vel);
        check_window(2 * 28 + 6);
    endtask

    task automatic test_retune_pan();
        int vel;
        vel = random_velocity();
        // data bytes only, status 90 still running
        tx_q = '{8'd110, 8'(vel)};
        send_queued();
        start_note(110, vel);
        check_window(2 * 18 + 4);
        // pan hard towards left, phase keeps running
        tx_q = '{8'hB0, 8'h0A, 8'd32};
        send_queued();
        exp_pan = 32;
        check_window(40);
    endtask

    task automatic test_filtering();
        // other channel, nothing changes
        tx_q = '{8'h93, 8'h40, 8'h7F};
        send_queued();
        check_window(20);
        // timing clock between the data bytes
        tx_q = '{8'h90, 8'd100, 8'hF8, 8'd80};
        send_queued();
        start_note(100, 80);
        check_window(2 * 28 + 4);
        tx_q = '{8'h90, 8'd100, 8'h00};
        send_queued();
        exp_gate = 1'b0;
        check_window(8);
        tx_q = '{8'h90, 8'd100, 8'h7F};
        send_queued();
        start_note(100, 127);
        check_window(8);
        tx_q = '{8'h80, 8'd100, 8'h40};
        send_queued();
        exp_gate = 1'b0;
        check_window(8);
    endtask

    initial begin
        midi_rx = 1'b1;
        wait (rst_n === 1'b1);
        @(negedge clk);
        assert (sample_valid == 1'b0 && dac_out_l == 1'b0 && dac_out_r == 1'b0) else
            report_fail("outputs not cleared by reset");
        test_idle();
        test_note_on();
        test_retune_pan();
        test_filtering();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verilog
verilog/synth_pkg.sv
verilog/uart_rx.sv
verilog/midi_decoder.sv
verilog/sample_rate_ctrl.sv
verilog/gen_pulse.sv
verilog/stereo_dac_output.sv
verilog/synth_top.sv
testbench/tb_clock.sv
testbench/synth_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the synth testbench with verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module synth_tb -f verilog.f &&
./obj_dir/Vsynth_tb ||
{ echo "simulation failed"; exit 1; }
